// File: Makefile
TOP = vec_dpath_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: tb.f
+incdir+test
verilog/vec_pkg.sv
verilog/vec_alu_lane.sv
verilog/vec_regfile.sv
verilog/vec_decode.sv
verilog/vec_execute.sv
verilog/vec_result.sv
verilog/vec_dpath.sv
test/vec_dpath_tb.sv

// File: test/vec_model.svh
/*
  Reference model, included inside the testbench module.
  Uses the module's shadow registers and LFSR state, so it is not standalone.
*/
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

// --------------------------------------------------
// Random numbers
// --------------------------------------------------

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr[0]};
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
  end
  return v;
endfunction

function automatic logic [4:0] rand_reg();
  return 5'(rand_bits(3));
endfunction

// The k-th of the nine lane ALU functions, wrapping around
function automatic logic [5:0] fn_at(input int k);
  logic [5:0] fns [9];
  fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
  return fns[k % 9];
endfunction

// One of the nine lane ALU functions
function automatic logic [5:0] rand_fn();
  return fn_at(int'(rand_bits(4)));
endfunction

// --------------------------------------------------
// Encoding
// --------------------------------------------------
function automatic logic [31:0] encode(input logic [5:0] f6, input logic [4:0] vs2,
                                       input logic [4:0] vs1, input logic [2:0] f3,
                                       input logic [4:0] vd);
  return {f6, 1'b0, vs2, vs1, f3, vd, OP_V};
endfunction

// vor.vv vr, vr, vr leaves vr unchanged and returns its contents
function automatic logic [31:0] readback(input logic [4:0] r);
  return encode(FN_OR, r, r, F3_IVV, r);
endfunction

// --------------------------------------------------
// Expected results
// --------------------------------------------------
function automatic logic fn_known(input logic [5:0] f6);
  return f6 inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT,
                    FN_SLL, FN_SRL, FN_SRA, FN_ADDR};
endfunction

function automatic lane_t lane_op(input logic [5:0] f6, input lane_t a, input lane_t b);
  case (f6)
    FN_ADD:  return a + b;
    FN_SUB:  return a - b;
    FN_AND:  return a & b;
    FN_OR:   return a | b;
    FN_XOR:  return a ^ b;
    FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    FN_SLL:  return a << b[4:0];
    FN_SRL:  return a >> b[4:0];
    FN_SRA:  return lane_t'($signed(a) >>> b[4:0]);
    default: return '0;
  endcase
endfunction

// Updates the shadow registers and gives the expected result and illegal flag
function automatic void ref_exec(input logic [31:0] w, input lane_t s, input lane_idx_t last,
                                 output lane_vec_t exp_res, output logic exp_ill);
  logic [5:0] f6;
  logic [2:0] f3;
  logic [4:0] vd;
  logic [4:0] vs1;
  logic [4:0] vs2;
  lane_t      b;
  lane_vec_t  nv;
  f6  = w[31:26];
  vs2 = w[24:20];
  vs1 = w[19:15];
  f3  = w[14:12];
  vd  = w[11:7];
  exp_ill = (w[6:0] != OP_V) || !(f3 inside {F3_IVV, F3_IVI, F3_IVX}) || !fn_known(f6) ||
            (f6 == FN_ADDR && f3 != F3_IVX) || (vd[4:3] != 2'b00) ||
            (vs2[4:3] != 2'b00) || (f3 == F3_IVV && vs1[4:3] != 2'b00);
  exp_res = '0;
  if (exp_ill) begin
    return;
  end
  // Lanes above last keep the old value
  nv = shadow[vd[2:0]];
  for (int l = 0; l <= int'(last); l++) begin
    if (f3 == F3_IVV) begin
      b = shadow[vs1[2:0]][l];
    end else if (f3 == F3_IVI) begin
      b = {{27{vs1[4]}}, vs1};
    end else begin
      b = s;
    end
    if (f6 == FN_ADDR) begin
      nv[l] = s + lane_t'(l) * shadow[vs2[2:0]][0];
    end else begin
      nv[l] = lane_op(f6, shadow[vs2[2:0]][l], b);
    end
  end
  shadow[vd[2:0]] = nv;
  exp_res = nv;
endfunction

`endif

// File: test/vec_dpath_tb.sv
/*
  Testbench for the vector unit, fixed-seed random stimulus.
  Expected values come from the model in vec_model.svh.
*/
`default_nettype none

module vec_dpath_tb import vec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RAND = 40;
  // Transactions per test: reset, vv random with preload, broadcast, lane_last, addr, illegal
  localparam int NUM_TXNS = 9 + 8 + N_RAND + 8 + 12 + 4 + 10;
  localparam int CLK_NS = 4;
  localparam lane_idx_t ALL_LANES = 2'd3;

  logic        clk;
  logic        reset;
  logic        req;
  logic [31:0] inst;
  lane_t       scalar;
  lane_idx_t   lane_last;
  logic        ack;
  lane_vec_t   result;
  logic        illegal;

  lane_vec_t   shadow [NUM_VREGS];
  logic [31:0] lfsr = 32'h8780fa39;
  string       cur_test;
  int          errors;
  int          test_errs;
  int          num_tests;

  // Finished transactions waiting for the compare process
  logic [31:0] q_inst [$];
  lane_t       q_scalar [$];
  lane_idx_t   q_last [$];
  lane_vec_t   q_res [$];
  logic        q_ill [$];

  `include "vec_model.svh"

  vec_dpath dut0 (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .inst      (inst),
    .scalar    (scalar),
    .lane_last (lane_last),
    .ack       (ack),
    .result    (result),
    .illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  // One full four-phase handshake
  task automatic transact(input logic [31:0] w, input lane_t s, input lane_idx_t last);
    @(posedge clk);
    #1;
    inst      = w;
    scalar    = s;
    lane_last = last;
    req       = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    q_inst.push_back(w);
    q_scalar.push_back(s);
    q_last.push_back(last);
    q_res.push_back(result);
    q_ill.push_back(illegal);
    req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (ack);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    while (q_inst.size() != 0) begin
      @(posedge clk);
    end
    $display("Test %-10s finished with %0d errors", cur_test, test_errs);
    num_tests++;
  endtask

  // Compare process
  initial begin
    lane_vec_t exp_res;
    logic      exp_ill;
    forever begin
      @(posedge clk);
      while (q_inst.size() > 0) begin
        ref_exec(q_inst.pop_front(), q_scalar.pop_front(), q_last.pop_front(),
                 exp_res, exp_ill);
        check(cur_test, exp_res, q_res.pop_front());
        check(cur_test, 128'(exp_ill), 128'(q_ill.pop_front()));
      end
    end
  end

  initial begin
    logic [4:0]  vd;
    logic [31:0] bad [5];
    req       = 1'b0;
    inst      = '0;
    scalar    = '0;
    lane_last = '0;
    reset     = 1'b1;
    errors    = 0;
    test_errs = 0;
    num_tests = 0;
    for (int r = 0; r < NUM_VREGS; r++) begin
      shadow[r] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test("reset");
    transact(encode(FN_ADD, 5'd0, 5'd0, F3_IVV, 5'd1), '0, ALL_LANES);
    for (int r = 0; r < NUM_VREGS; r++) begin
      transact(readback(5'(r)), '0, ALL_LANES);
    end
    end_test();

    // Preload distinct lanes, each register strided from the one before
    start_test("vv_random");
    for (int r = 0; r < NUM_VREGS; r++) begin
      transact(encode(FN_ADDR, 5'((r + 7) % 8), 5'd0, F3_IVX, 5'(r)), rand_bits(32), ALL_LANES);
    end
    // Every function comes round in turn, registers random
    for (int i = 0; i < N_RAND; i++) begin
      transact(encode(fn_at(i), rand_reg(), rand_reg(), F3_IVV, rand_reg()), '0, ALL_LANES);
    end
    end_test();

    start_test("broadcast");
    repeat (4) begin
      transact(encode(rand_fn(), rand_reg(), 5'(rand_bits(5)), F3_IVI, rand_reg()), '0,
               ALL_LANES);
    end
    repeat (4) begin
      transact(encode(rand_fn(), rand_reg(), 5'd0, F3_IVX, rand_reg()), rand_bits(32),
               ALL_LANES);
    end
    end_test();

    start_test("lane_last");
    repeat (6) begin
      vd = rand_reg();
      transact(encode(rand_fn(), rand_reg(), rand_reg(), F3_IVV, vd), '0,
               lane_idx_t'(rand_bits(2) % 3));
      transact(readback(vd), '0, ALL_LANES);
    end
    end_test();

    start_test("addr_gen");
    repeat (4) begin
      transact(encode(FN_ADDR, rand_reg(), 5'd0, F3_IVX, rand_reg()), rand_bits(32), ALL_LANES);
    end
    end_test();

    start_test("illegal");
    // Opcode 0x57 flipped to 0x33
    bad[0] = encode(FN_ADD, 5'd1, 5'd2, F3_IVV, 5'd3) ^ 32'h64;
    bad[1] = encode(6'd5, 5'd1, 5'd2, F3_IVV, 5'd4);
    bad[2] = encode(FN_ADDR, 5'd1, 5'd2, F3_IVV, 5'd5);
    bad[3] = encode(FN_ADD, 5'd1, 5'd2, F3_IVV, 5'd14);
    bad[4] = encode(FN_ADD, 5'd1, 5'd2, 3'd1, 5'd7);
    foreach (bad[k]) begin
      transact(bad[k], 32'h1234, ALL_LANES);
      transact(readback(5'(bad[k][9:7])), '0, ALL_LANES);
    end
    end_test();

    $display("Tests run: %0d, errors: %0d", num_tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog, 20 cycles per transaction plus reset
  initial begin
    #((NUM_TXNS * 20 + 5) * CLK_NS);
    $display("Timeout: the DUT stopped completing handshakes");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/vec_alu_lane.sv
/*
  Combinational ALU for one 32-bit lane.
  Shift amounts use only the low 5 bits of b.
*/
`default_nettype none

module vec_alu_lane import vec_pkg::*; (
  input  lane_t   a,
  input  lane_t   b,
  input  alu_fn_t fn,
  output lane_t   result
);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (fn)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      // Signed compare
      ALU_SLT: result = ($signed(a) < $signed(b)) ? lane_t'(1) : '0;
      ALU_SLL: result = a << shamt;
      ALU_SRL: result = a >> shamt;
      ALU_SRA: result = lane_t'($signed(a) >>> shamt);
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/vec_decode.sv
/*
  Accepts one four-phase request at a time and issues it one cycle later.
  inst, scalar and lane_last are sampled only on the accept edge.
*/
`default_nettype none

module vec_decode import vec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  input  logic [31:0] inst,
  input  lane_t       scalar,
  input  lane_idx_t   lane_last,
  input  logic        ack,
  output vreg_addr_t  raddr_a,
  output vreg_addr_t  raddr_b,
  input  lane_vec_t   rdata_a,
  input  lane_vec_t   rdata_b,
  output logic        iss_valid,
  output alu_fn_t     iss_fn,
  output logic        iss_addr_gen,
  output lane_vec_t   op_a,
  output lane_vec_t   op_b,
  output lane_t       base,
  output vreg_addr_t  iss_vd,
  output lane_idx_t   iss_lane_last,
  output logic        iss_illegal
);

  logic       busy;
  logic       accept;
  logic [6:0] opcode;
  logic [4:0] vd_field;
  logic [2:0] funct3;
  logic [4:0] vs1_field;
  logic [4:0] vs2_field;
  logic [5:0] funct6;
  lane_t      imm_ext;
  alu_fn_t    fn_sel;
  logic       fn_ok;
  logic       addr_gen;
  logic       form_ok;
  logic       regs_ok;
  logic       illegal_sel;
  lane_vec_t  op_b_sel;

  assign accept = req && !busy;

  // ------------------------------------------------
  // Field parsing
  // ------------------------------------------------
  assign opcode    = inst[OPCODE_HI:OPCODE_LO];
  assign vd_field  = inst[VD_HI:VD_LO];
  assign funct3    = inst[F3_HI:F3_LO];
  assign vs1_field = inst[VS1_HI:VS1_LO];
  assign vs2_field = inst[VS2_HI:VS2_LO];
  assign funct6    = inst[F6_HI:F6_LO];

  assign raddr_a = vs2_field[VREG_AW-1:0];
  assign raddr_b = vs1_field[VREG_AW-1:0];

  // simm5 shares the vs1 slot
  assign imm_ext = {{(XLEN-5){vs1_field[4]}}, vs1_field};

  always_comb begin
    fn_ok    = 1'b1;
    addr_gen = 1'b0;
    fn_sel   = ALU_ADD;
    case (funct6)
      FN_ADD:  fn_sel = ALU_ADD;
      FN_SUB:  fn_sel = ALU_SUB;
      FN_AND:  fn_sel = ALU_AND;
      FN_OR:   fn_sel = ALU_OR;
      FN_XOR:  fn_sel = ALU_XOR;
      FN_SLT:  fn_sel = ALU_SLT;
      FN_SLL:  fn_sel = ALU_SLL;
      FN_SRL:  fn_sel = ALU_SRL;
      FN_SRA:  fn_sel = ALU_SRA;
      FN_ADDR: addr_gen = 1'b1;
      default: fn_ok = 1'b0;
    endcase
  end

  // Illegal detection
  assign form_ok = (funct3 == F3_IVV) || (funct3 == F3_IVI) || (funct3 == F3_IVX);
  assign regs_ok = (vd_field[4:VREG_AW] == '0) && (vs2_field[4:VREG_AW] == '0) &&
                   ((funct3 != F3_IVV) || (vs1_field[4:VREG_AW] == '0));
  assign illegal_sel = (opcode != OP_V) || !form_ok || !fn_ok || !regs_ok ||
                       (addr_gen && (funct3 != F3_IVX));

  // Operand B, address generation takes its stride from lane 0 of vs2
  always_comb begin
    case (funct3)
      F3_IVI:  op_b_sel = {NUM_LANES{imm_ext}};
      F3_IVX:  op_b_sel = addr_gen ? rdata_a : {NUM_LANES{scalar}};
      default: op_b_sel = rdata_b;
    endcase
  end

  // ------------------------------------------------
  // Busy flag and issue register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (!req && !ack) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss_fn        <= fn_sel;
      iss_addr_gen  <= addr_gen;
      op_a          <= rdata_a;
      op_b          <= op_b_sel;
      base          <= scalar;
      iss_vd        <= vd_field[VREG_AW-1:0];
      iss_lane_last <= lane_last;
      iss_illegal   <= illegal_sel;
    end
  end

  // Busy must cover the whole handshake, so no accept while ack is still up
  a_accept_after_ack: assert property (
    @(posedge clk) disable iff (reset) accept |-> !ack
  ) else $error("request accepted while ack of the previous one was still high");

endmodule

`default_nettype wire

// File: verilog/vec_dpath.sv
/*
  Vector unit top level, one instruction in flight under four-phase req/ack.
  Accept to ack is three cycles; req may rise again only after ack is low.
*/
`default_nettype none

module vec_dpath import vec_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        req,
  input  logic [31:0] inst,
  input  lane_t       scalar,
  input  lane_idx_t   lane_last,
  output logic        ack,
  output lane_vec_t   result,
  output logic        illegal
);

  // Register file ports
  vreg_addr_t           raddr_a;
  vreg_addr_t           raddr_b;
  lane_vec_t            rdata_a;
  lane_vec_t            rdata_b;
  lane_vec_t            rdata_c;
  logic                 wr_en;
  vreg_addr_t           wr_addr;
  logic [NUM_LANES-1:0] wr_lane_mask;
  lane_vec_t            wr_data;

  // Decode to execute
  logic       iss_valid;
  alu_fn_t    iss_fn;
  logic       iss_addr_gen;
  lane_vec_t  op_a;
  lane_vec_t  op_b;
  lane_t      base;
  vreg_addr_t iss_vd;
  lane_idx_t  iss_lane_last;
  logic       iss_illegal;

  // Execute to result
  logic       ex_valid;
  lane_vec_t  ex_data;
  vreg_addr_t ex_vd;
  lane_idx_t  ex_lane_last;
  logic       ex_illegal;

  vec_decode u_decode (
    .clk, .reset, .req, .inst, .scalar, .lane_last, .ack,
    .raddr_a, .raddr_b, .rdata_a, .rdata_b,
    .iss_valid, .iss_fn, .iss_addr_gen, .op_a, .op_b, .base,
    .iss_vd, .iss_lane_last, .iss_illegal
  );

  vec_regfile u_regfile (
    .clk, .reset,
    .raddr_a, .rdata_a, .raddr_b, .rdata_b,
    .raddr_c (ex_vd), .rdata_c,
    .wr_en, .wr_addr, .wr_lane_mask, .wr_data
  );

  vec_execute u_execute (
    .clk, .reset,
    .iss_valid, .iss_fn, .iss_addr_gen, .op_a, .op_b, .base,
    .iss_vd, .iss_lane_last, .iss_illegal,
    .ex_valid, .ex_data, .ex_vd, .ex_lane_last, .ex_illegal
  );

  vec_result u_result (
    .clk, .reset, .req,
    .ex_valid, .ex_data, .ex_vd, .ex_lane_last, .ex_illegal,
    .rd_data (rdata_c),
    .wr_en, .wr_addr, .wr_lane_mask, .wr_data,
    .ack, .result, .illegal
  );

endmodule

`default_nettype wire

// File: verilog/vec_execute.sv
/*
  Four lane ALUs and the strided address generator, registered once.
  Addresses are base plus lane index times lane 0 of op_b, modulo 2^32.
*/
`default_nettype none

module vec_execute import vec_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       iss_valid,
  input  alu_fn_t    iss_fn,
  input  logic       iss_addr_gen,
  input  lane_vec_t  op_a,
  input  lane_vec_t  op_b,
  input  lane_t      base,
  input  vreg_addr_t iss_vd,
  input  lane_idx_t  iss_lane_last,
  input  logic       iss_illegal,
  output logic       ex_valid,
  output lane_vec_t  ex_data,
  output vreg_addr_t ex_vd,
  output lane_idx_t  ex_lane_last,
  output logic       ex_illegal
);

  lane_vec_t alu_out;
  lane_vec_t addr_out;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vec_alu_lane u_alu (
      .a      (op_a[i]),
      .b      (op_b[i]),
      .fn     (iss_fn),
      .result (alu_out[i])
    );

    // Stride is taken from lane 0 only
    assign addr_out[i] = base + op_b[0] * lane_t'(i);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid) begin
      ex_data      <= iss_addr_gen ? addr_out : alu_out;
      ex_vd        <= iss_vd;
      ex_lane_last <= iss_lane_last;
      ex_illegal   <= iss_illegal;
    end
  end

endmodule

`default_nettype wire

// File: verilog/vec_pkg.sv
/*
  Shared sizes, field positions and codes for the vector unit.
  Register fields are 5 bits wide in the instruction, but only 8 registers exist.
*/
`default_nettype none

package vec_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int XLEN       = 32;
  localparam int NUM_LANES  = 4;
  localparam int NUM_VREGS  = 8;
  localparam int VREG_AW    = 3;
  localparam int LANE_IDX_W = 2;
  localparam int SHAMT_W    = 5;

  typedef logic [XLEN-1:0]                 lane_t;
  // Lane 0 sits in the low bits
  typedef logic [NUM_LANES-1:0][XLEN-1:0]  lane_vec_t;
  typedef logic [VREG_AW-1:0]              vreg_addr_t;
  typedef logic [LANE_IDX_W-1:0]           lane_idx_t;

  // ------------------------------------------------
  // Instruction fields
  // ------------------------------------------------
  localparam int OPCODE_HI = 6;
  localparam int OPCODE_LO = 0;
  localparam int VD_HI     = 11;
  localparam int VD_LO     = 7;
  localparam int F3_HI     = 14;
  localparam int F3_LO     = 12;
  localparam int VS1_HI    = 19;
  localparam int VS1_LO    = 15;
  localparam int VS2_HI    = 24;
  localparam int VS2_LO    = 20;
  localparam int F6_HI     = 31;
  localparam int F6_LO     = 26;

  localparam logic [6:0] OP_V = 7'h57;

  // Operand forms
  localparam logic [2:0] F3_IVV = 3'd0;
  localparam logic [2:0] F3_IVI = 3'd3;
  localparam logic [2:0] F3_IVX = 3'd4;

  // funct6 codes
  localparam logic [5:0] FN_ADD  = 6'd0;
  localparam logic [5:0] FN_SUB  = 6'd2;
  localparam logic [5:0] FN_AND  = 6'd9;
  localparam logic [5:0] FN_OR   = 6'd10;
  localparam logic [5:0] FN_XOR  = 6'd11;
  localparam logic [5:0] FN_SLT  = 6'd27;
  localparam logic [5:0] FN_SLL  = 6'd37;
  localparam logic [5:0] FN_SRL  = 6'd40;
  localparam logic [5:0] FN_SRA  = 6'd41;
  localparam logic [5:0] FN_ADDR = 6'd63;

  // Lane ALU operations, FN_ADDR goes through the address generator instead
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_fn_t;

endpackage

`default_nettype wire

// File: verilog/vec_regfile.sv
/*
  Eight vector registers, three combinational read ports, one lane-masked write.
  A read of the register being written returns the old contents.
*/
`default_nettype none

module vec_regfile import vec_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  vreg_addr_t           raddr_a,
  output lane_vec_t            rdata_a,
  input  vreg_addr_t           raddr_b,
  output lane_vec_t            rdata_b,
  input  vreg_addr_t           raddr_c,
  output lane_vec_t            rdata_c,
  input  logic                 wr_en,
  input  vreg_addr_t           wr_addr,
  input  logic [NUM_LANES-1:0] wr_lane_mask,
  input  lane_vec_t            wr_data
);

  lane_vec_t regs [NUM_VREGS];

  // Read ports
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];
  assign rdata_c = regs[raddr_c];

  // Write port, only the masked lanes change
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wr_lane_mask[l]) begin
          regs[wr_addr][l] <= wr_data[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/vec_result.sv
/*
  Writeback of lanes 0..lane_last and the ack side of the four-phase handshake.
  result holds the destination's new contents, or zero for an illegal instruction.
*/
`default_nettype none

module vec_result import vec_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic                 ex_valid,
  input  lane_vec_t            ex_data,
  input  vreg_addr_t           ex_vd,
  input  lane_idx_t            ex_lane_last,
  input  logic                 ex_illegal,
  input  lane_vec_t            rd_data,
  output logic                 wr_en,
  output vreg_addr_t           wr_addr,
  output logic [NUM_LANES-1:0] wr_lane_mask,
  output lane_vec_t            wr_data,
  output logic                 ack,
  output lane_vec_t            result,
  output logic                 illegal
);

  logic [NUM_LANES-1:0] lane_mask;
  lane_vec_t            merged;

  // Lanes 0 through ex_lane_last are active
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_mask[l] = (l <= int'(ex_lane_last));
      merged[l]    = lane_mask[l] ? ex_data[l] : rd_data[l];
    end
  end

  assign wr_en        = ex_valid && !ex_illegal;
  assign wr_addr      = ex_vd;
  assign wr_lane_mask = lane_mask;
  assign wr_data      = ex_data;

  // ------------------------------------------------
  // Result register and ack
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      result  <= ex_illegal ? '0 : merged;
      illegal <= ex_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (ex_valid) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (reset) $rose(ack) |-> $past(req)
  ) else $error("ack rose without an outstanding req");

  // A new result never lands on top of an unfinished handshake
  a_no_overlap: assert property (
    @(posedge clk) disable iff (reset) ex_valid |-> !ack
  ) else $error("ex_valid arrived while ack was still high");

endmodule

`default_nettype wire
